// ==== source/hazardPkg.sv ====
// Widths, opcode encoding and the packed control structs shared by the
// hazard-control slice of the 16-bit five-stage pipeline
package hazardPkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int regIdW = 4;    // 16 registers, r0 reads as zero
  localparam int instrW = 16;   // Instruction word
  localparam int opW    = 4;    // Opcode field, instr[15:12]
  localparam int cntW   = 16;   // Performance counter width
  localparam int numCnt = 4;    // Load-use, branch, halt, flush

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  typedef enum logic [opW-1:0] {
    ADD    = 4'h0,
    SUB    = 4'h1,
    XOR    = 4'h2,
    RED    = 4'h3,
    SLL    = 4'h4,
    SRA    = 4'h5,
    ROR    = 4'h6,
    PADDSB = 4'h7,
    LW     = 4'h8,   // Memory read
    SW     = 4'h9,   // Memory write, data reg sits in the rd field
    LLB    = 4'hA,   // Load low byte, reads and writes rd
    LHB    = 4'hB,   // Load high byte, reads and writes rd
    B      = 4'hC,   // Conditional branch on flags
    BR     = 4'hD,   // Conditional branch to register rs
    PCS    = 4'hE,   // Save PC+2 into rd
    HLT    = 4'hF
  } opcodeE;

  // ADD r0, r0, r0 writes nothing visible
  localparam logic [instrW-1:0] nopInstr = {ADD, 12'h000};

  //////////////////////////////
  // Control structs
  //////////////////////////////

  // Everything the decode stage knows about its instruction (20 bits)
  typedef struct packed {
    logic [regIdW-1:0] srcReg1;   // rs, or rd for LLB/LHB
    logic [regIdW-1:0] srcReg2;   // rt, or rd for SW
    logic [regIdW-1:0] destReg;   // Zero when nothing is written
    logic              regWrite;
    logic              memEnable;
    logic              memWrite;
    logic              zEn;       // Sets the Z flag
    logic              nvEn;      // Sets the N and V flags
    logic              branch;    // B instruction
    logic              br;        // BR instruction
    logic              hlt;
  } decodeCtrlS;

  // Fields carried down ID/EX and EX/MEM (9 bits)
  typedef struct packed {
    logic [regIdW-1:0] destReg;
    logic              regWrite;
    logic              memEnable;
    logic              memWrite;
    logic              zEn;
    logic              nvEn;
  } stageCtrlS;

  // All flags low, the pipeline bubble
  localparam stageCtrlS bubbleCtrl = '0;

  // Why the front end is held this cycle (4 bits)
  typedef struct packed {
    logic loadUse;
    logic bHazard;
    logic brHazard;
    logic hlt;
  } hazardCauseS;

endpackage

// ==== source/instrDecoder.sv ====
// Decode of the IF/ID instruction word into the decode-stage control struct
`timescale 1ns/1ps

module instrDecoder import hazardPkg::*; (
  input  logic [instrW-1:0] instr,   // IF/ID instruction register
  output decodeCtrlS        idCtrl   // Decoded fields for hazard check and ID/EX
);

  //////////////////////////////
  // Field split
  //////////////////////////////
  opcodeE            op;
  logic [regIdW-1:0] rdF;   // instr[11:8]
  logic [regIdW-1:0] rsF;   // instr[7:4]
  logic [regIdW-1:0] rtF;   // instr[3:0]
  logic              aluOp; // One of the eight ALU operations

  assign op    = opcodeE'(instr[instrW-1 -: opW]);
  assign rdF   = instr[11:8];
  assign rsF   = instr[7:4];
  assign rtF   = instr[3:0];
  assign aluOp = ~instr[instrW-1];   // Opcodes 0..7

  //////////////////////////////
  // Control flags
  //////////////////////////////
  always_comb begin
    idCtrl = '0;

    // Register writers: ALU ops, loads, byte loads and PCS
    idCtrl.regWrite = aluOp | (op == LW) | (op == LLB) | (op == LHB) | (op == PCS);

    idCtrl.memEnable = (op == LW) | (op == SW);
    idCtrl.memWrite  = (op == SW);

    // RED and PADDSB leave the flags alone
    unique case (op)
      ADD, SUB:            idCtrl.zEn = 1'b1;
      XOR, SLL, SRA, ROR:  idCtrl.zEn = 1'b1;
      default:             idCtrl.zEn = 1'b0;
    endcase
    idCtrl.nvEn = (op == ADD) | (op == SUB);   // Only arithmetic can overflow

    idCtrl.branch = (op == B);
    idCtrl.br     = (op == BR);
    idCtrl.hlt    = (op == HLT);

    // Destination only when something is written, so stores never match
    idCtrl.destReg = idCtrl.regWrite ? rdF : '0;

    // Sources
    case (op)
      LLB, LHB: begin
        idCtrl.srcReg1 = rdF;   // Byte load merges into the old rd
        idCtrl.srcReg2 = rtF;
      end
      SW: begin
        idCtrl.srcReg1 = rsF;   // Base address
        idCtrl.srcReg2 = rdF;   // Store data
      end
      B, PCS, HLT: begin
        idCtrl.srcReg1 = '0;    // Reads no register
        idCtrl.srcReg2 = '0;
      end
      default: begin
        idCtrl.srcReg1 = rsF;
        idCtrl.srcReg2 = rtF;
      end
    endcase
  end

endmodule

// ==== source/controlPipeline.sv ====
// IF/ID instruction register and the ID/EX, EX/MEM control registers,
// with stall, flush and bubble insertion
`timescale 1ns/1ps

module controlPipeline import hazardPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [instrW-1:0] instrWord,   // From fetch
  input  decodeCtrlS        idCtrl,      // Decode of ifIdInstr
  input  logic              ifIdStall,   // Hold IF/ID
  input  logic              idFlush,     // Bubble into ID/EX
  input  logic              ifFlush,     // Kill the fetched word
  output logic [instrW-1:0] ifIdInstr,
  output stageCtrlS         exCtrl,      // ID/EX
  output stageCtrlS         memCtrl      // EX/MEM
);

  stageCtrlS idStage;   // Stage fields of the decode instruction

  // Branch and halt info stays behind in decode
  assign idStage = '{
    destReg:   idCtrl.destReg,
    regWrite:  idCtrl.regWrite,
    memEnable: idCtrl.memEnable,
    memWrite:  idCtrl.memWrite,
    zEn:       idCtrl.zEn,
    nvEn:      idCtrl.nvEn
  };

  //////////////////////////////
  // IF/ID
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      ifIdInstr <= nopInstr;
    end else if (ifFlush) begin
      ifIdInstr <= nopInstr;   // Wrong-path fetch, flush beats stall
    end else if (!ifIdStall) begin
      ifIdInstr <= instrWord;
    end
    // Otherwise hold, decode retries next cycle
  end

  //////////////////////////////
  // ID/EX and EX/MEM
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      exCtrl  <= bubbleCtrl;
      memCtrl <= bubbleCtrl;
    end else begin
      if (idFlush) begin
        exCtrl <= bubbleCtrl;   // Held instruction must not execute twice
      end else begin
        exCtrl <= idStage;
      end
      memCtrl <= exCtrl;        // Never stalled
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // A flush request has to show up as a bubble in EX on the next cycle
  bubbleAfterFlush: assert property (
    @(posedge clk) disable iff (rst)
    idFlush |=> (exCtrl == bubbleCtrl)
  ) else $error("ID/EX not a bubble after idFlush");

endmodule

// ==== source/hazardDetectionUnit.sv ====
// Load-to-use, B and BR hazard detection and the stall/flush controls
`timescale 1ns/1ps

module hazardDetectionUnit import hazardPkg::*; (
  input  decodeCtrlS  idCtrl,        // Instruction in decode
  input  stageCtrlS   exCtrl,        // ID/EX
  input  stageCtrlS   memCtrl,       // EX/MEM
  input  logic        branchTaken,   // PC update from branch resolution
  output logic        pcStall,
  output logic        ifIdStall,
  output logic        idFlush,
  output logic        ifFlush,
  output hazardCauseS hazardCause
);

  logic exMemRead;    // LW in EX
  logic exDestLive;   // EX writes a real register
  logic memDestLive;  // MEM writes a real register
  logic exSetsFlag;   // Flags not settled until EX finishes
  logic exBrMatch;    // EX produces the BR target register
  logic memBrMatch;   // MEM produces the BR target register
  logic holdFront;    // Any hazard that holds fetch and decode

  //////////////////////////////
  // Load-to-use
  //////////////////////////////
  assign exMemRead  = exCtrl.memEnable & ~exCtrl.memWrite;
  assign exDestLive = exCtrl.regWrite & (exCtrl.destReg != '0);

  // Store data matching the load is served by MEM-to-MEM forwarding
  assign hazardCause.loadUse = exMemRead & (exCtrl.destReg != '0) &
                               ((exCtrl.destReg == idCtrl.srcReg1) |
                                ((exCtrl.destReg == idCtrl.srcReg2) & ~idCtrl.memWrite));

  //////////////////////////////
  // Branches
  //////////////////////////////
  assign exSetsFlag  = exCtrl.zEn | exCtrl.nvEn;
  assign memDestLive = memCtrl.regWrite & (memCtrl.destReg != '0);

  assign exBrMatch  = exDestLive & (exCtrl.destReg == idCtrl.srcReg1);
  assign memBrMatch = memDestLive & (memCtrl.destReg == idCtrl.srcReg1);

  assign hazardCause.bHazard  = idCtrl.branch & exSetsFlag;   // Condition not ready
  // BR needs both the condition and its target register from rs
  assign hazardCause.brHazard = idCtrl.br & (exSetsFlag | exBrMatch | memBrMatch);

  assign hazardCause.hlt = idCtrl.hlt;

  //////////////////////////////
  // Pipeline controls
  //////////////////////////////
  assign holdFront = hazardCause.loadUse | hazardCause.bHazard | hazardCause.brHazard;

  assign pcStall   = holdFront | hazardCause.hlt;   // HLT freezes the PC only
  assign ifIdStall = holdFront;   // HLT keeps moving so it drains to WB
  assign idFlush   = holdFront;   // Bubble behind the held instruction
  assign ifFlush   = branchTaken;

  // Decode can only be held while the PC is held too
  always_comb begin : stallCheck
    if (ifIdStall) begin
      stallNeedsPc: assert (pcStall) else $error("ifIdStall without pcStall");
    end
  end

endmodule

// ==== source/perfCounters.sv ====
// Saturating counters of load-use, branch and halt stall cycles and of flushes
`timescale 1ns/1ps

module perfCounters import hazardPkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  hazardCauseS     hazardCause,
  input  logic            ifFlush,
  output logic [cntW-1:0] loadUseCount,
  output logic [cntW-1:0] branchStallCount,
  output logic [cntW-1:0] haltStallCount,
  output logic [cntW-1:0] flushCount
);

  logic [numCnt-1:0] bump;           // One cause bit per counter
  logic [cntW-1:0]   cnt [numCnt];

  assign bump[0] = hazardCause.loadUse;
  assign bump[1] = hazardCause.bHazard | hazardCause.brHazard;   // Both branch kinds
  assign bump[2] = hazardCause.hlt;
  assign bump[3] = ifFlush;

  //////////////////////////////
  // Counters
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numCnt; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < numCnt; i++) begin
        if (bump[i] && (cnt[i] != '1)) cnt[i] <= cnt[i] + 1'b1;   // Stick at all ones
      end
    end
  end

  assign loadUseCount     = cnt[0];
  assign branchStallCount = cnt[1];
  assign haltStallCount   = cnt[2];
  assign flushCount       = cnt[3];

  // Counts only go up between resets
  for (genvar g = 0; g < numCnt; g++) begin : gMono
    noDecrease: assert property (
      @(posedge clk) disable iff (rst)
      cnt[g] >= $past(cnt[g])
    ) else $error("Counter %0d decreased", g);
  end

endmodule

// ==== source/hazardPipeCtrl.sv ====
// Top of the hazard-control slice: decoder, control pipeline, hazard unit
// and performance counters
`timescale 1ns/1ps

module hazardPipeCtrl import hazardPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [instrW-1:0] instrWord,      // Fetched word
  input  logic              branchTaken,    // PC update level
  output logic              pcStall,
  output logic              ifIdStall,
  output logic              idFlush,
  output logic              ifFlush,
  output stageCtrlS         exCtrl,         // What the datapath has in EX
  output logic [cntW-1:0]   loadUseCount,
  output logic [cntW-1:0]   branchStallCount,
  output logic [cntW-1:0]   haltStallCount,
  output logic [cntW-1:0]   flushCount
);

  logic [instrW-1:0] ifIdInstr;
  decodeCtrlS        idCtrl;
  stageCtrlS         memCtrl;
  hazardCauseS       hazardCause;

  instrDecoder uDecoder (
    .instr  (ifIdInstr),
    .idCtrl (idCtrl)
  );

  controlPipeline uPipe (
    .clk       (clk),
    .rst       (rst),
    .instrWord (instrWord),
    .idCtrl    (idCtrl),
    .ifIdStall (ifIdStall),
    .idFlush   (idFlush),
    .ifFlush   (ifFlush),
    .ifIdInstr (ifIdInstr),
    .exCtrl    (exCtrl),
    .memCtrl   (memCtrl)
  );

  // Sole source of the stall and flush levels
  hazardDetectionUnit uHazard (
    .idCtrl      (idCtrl),
    .exCtrl      (exCtrl),
    .memCtrl     (memCtrl),
    .branchTaken (branchTaken),
    .pcStall     (pcStall),
    .ifIdStall   (ifIdStall),
    .idFlush     (idFlush),
    .ifFlush     (ifFlush),
    .hazardCause (hazardCause)
  );

  perfCounters uCounters (
    .clk              (clk),
    .rst              (rst),
    .hazardCause      (hazardCause),
    .ifFlush          (ifFlush),
    .loadUseCount     (loadUseCount),
    .branchStallCount (branchStallCount),
    .haltStallCount   (haltStallCount),
    .flushCount       (flushCount)
  );

endmodule

// ==== dv/hazardPipeCtrlTb.sv ====
// Testbench for the hazard-control slice: LFSR fetch stimulus, directed hazard
// sequences, shadow pipeline reference model and per-cycle compare
`timescale 1ns/1ps

module hazardPipeCtrlTb import hazardPkg::*; ();

  localparam int waitLimit      = 50;      // Cycles a fetch may be held
  localparam int randCount      = 2000;    // Random instructions to issue
  localparam int randCycleLimit = 20000;

  // Expected controls and their causes
  typedef struct packed {
    hazardCauseS cause;
    logic        pcStall;
    logic        ifIdStall;
    logic        idFlush;
    logic        ifFlush;
  } ctrlOutS;

  logic              clk;
  logic              rst;
  logic [instrW-1:0] instrWord;
  logic              branchTaken;
  logic              pcStall;
  logic              ifIdStall;
  logic              idFlush;
  logic              ifFlush;
  stageCtrlS         exCtrl;
  logic [cntW-1:0]   loadUseCount;
  logic [cntW-1:0]   branchStallCount;
  logic [cntW-1:0]   haltStallCount;
  logic [cntW-1:0]   flushCount;

  logic [31:0]       lfsrState;
  logic [instrW-1:0] modelIfId;            // Shadow IF/ID
  stageCtrlS         modelEx;              // Shadow ID/EX
  stageCtrlS         modelMem;             // Shadow EX/MEM
  logic [cntW-1:0]   modelCount [4];       // Load-use, branch, halt, flush
  logic [instrW-1:0] fillWord;             // PADDSB r0, no flags, no dest

  hazardPipeCtrl DUT (
    .clk              (clk),
    .rst              (rst),
    .instrWord        (instrWord),
    .branchTaken      (branchTaken),
    .pcStall          (pcStall),
    .ifIdStall        (ifIdStall),
    .idFlush          (idFlush),
    .ifFlush          (ifFlush),
    .exCtrl           (exCtrl),
    .loadUseCount     (loadUseCount),
    .branchStallCount (branchStallCount),
    .haltStallCount   (haltStallCount),
    .flushCount       (flushCount)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic failRun(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
      failRun($sformatf("mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual));
  endtask

  //////////////////////////////
  // Random source
  //////////////////////////////
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsrState[0]};
      // Galois form of x^32 + x^30 + x^26 + x^25 + 1
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hA300_0000) : (lfsrState >> 1);
    end
    return val;
  endfunction

  function automatic logic [instrW-1:0] mkInstr(input opcodeE op, input logic [3:0] rd,
                                                input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  // Weighted toward loads, stores, branches and flag setters; regs r0..r3 only
  function automatic logic [instrW-1:0] randWord();
    logic [2:0] pick;
    opcodeE     op;
    pick = 3'(takeBits(3));
    case (pick)
      3'd0:    op = LW;
      3'd1:    op = SW;
      3'd2:    op = B;
      3'd3:    op = BR;
      3'd4:    op = ADD;
      3'd5:    op = XOR;
      3'd6:    op = SUB;
      default: op = opcodeE'(4'(takeBits(4)));   // Anything, HLT included
    endcase
    return mkInstr(op, {2'b00, 2'(takeBits(2))}, {2'b00, 2'(takeBits(2))},
                   {2'b00, 2'(takeBits(2))});
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic decodeCtrlS refDecode(input logic [instrW-1:0] w);
    decodeCtrlS d;
    opcodeE     op;
    op = opcodeE'(w[15:12]);
    d = '0;
    d.regWrite  = (op inside {ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB, LW, LLB, LHB, PCS});
    d.zEn       = (op inside {ADD, SUB, XOR, SLL, SRA, ROR});
    d.nvEn      = (op inside {ADD, SUB});
    d.memEnable = (op inside {LW, SW});
    d.memWrite  = (op == SW);
    d.branch    = (op == B);
    d.br        = (op == BR);
    d.hlt       = (op == HLT);
    d.destReg   = d.regWrite ? w[11:8] : 4'd0;
    d.srcReg1   = (op inside {LLB, LHB}) ? w[11:8] : w[7:4];   // Byte loads read rd
    d.srcReg2   = (op == SW) ? w[11:8] : w[3:0];               // Store data in rd
    if (op inside {B, PCS, HLT}) begin
      d.srcReg1 = 4'd0;
      d.srcReg2 = 4'd0;
    end
    return d;
  endfunction

  function automatic stageCtrlS toStage(input decodeCtrlS d);
    stageCtrlS s;
    s.destReg   = d.destReg;
    s.regWrite  = d.regWrite;
    s.memEnable = d.memEnable;
    s.memWrite  = d.memWrite;
    s.zEn       = d.zEn;
    s.nvEn      = d.nvEn;
    return s;
  endfunction

  function automatic ctrlOutS refControls(input decodeCtrlS id, input stageCtrlS ex,
                                          input stageCtrlS mem, input logic taken);
    ctrlOutS r;
    logic    exRead;
    logic    exFlags;
    logic    hold;
    r       = '0;
    exRead  = ex.memEnable && !ex.memWrite;
    exFlags = ex.zEn || ex.nvEn;
    r.cause.loadUse = exRead && (ex.destReg != 4'd0) &&
                      ((ex.destReg == id.srcReg1) ||
                       ((ex.destReg == id.srcReg2) && !id.memWrite));
    r.cause.bHazard  = id.branch && exFlags;
    r.cause.brHazard = id.br && (exFlags ||
                       (ex.regWrite && (ex.destReg != 4'd0) && (ex.destReg == id.srcReg1)) ||
                       (mem.regWrite && (mem.destReg != 4'd0) && (mem.destReg == id.srcReg1)));
    r.cause.hlt = id.hlt;
    hold        = r.cause.loadUse || r.cause.bHazard || r.cause.brHazard;
    r.pcStall   = hold || id.hlt;
    r.ifIdStall = hold;
    r.idFlush   = hold;
    r.ifFlush   = taken;
    return r;
  endfunction

  // Shadow registers step on the same edge as the DUT
  always @(posedge clk) begin : shadowModel
    ctrlOutS exp;
    logic    bump [4];
    if (rst) begin
      modelIfId = nopInstr;
      modelEx   = '0;
      modelMem  = '0;
      for (int i = 0; i < 4; i++) modelCount[i] = '0;
    end else begin
      exp     = refControls(refDecode(modelIfId), modelEx, modelMem, branchTaken);
      bump[0] = exp.cause.loadUse;
      bump[1] = exp.cause.bHazard || exp.cause.brHazard;
      bump[2] = exp.cause.hlt;
      bump[3] = exp.ifFlush;
      for (int i = 0; i < 4; i++) begin
        if (bump[i] && (modelCount[i] != '1)) modelCount[i] = modelCount[i] + 16'd1;
      end
      modelMem = modelEx;
      modelEx  = exp.idFlush ? stageCtrlS'('0) : toStage(refDecode(modelIfId));
      if (exp.ifFlush) modelIfId = nopInstr;      // Flush beats stall
      else if (!exp.ifIdStall) modelIfId = instrWord;
    end
  end

  // Mid low phase, inputs and outputs have settled
  initial begin : compareLoop
    ctrlOutS exp;
    forever begin
      @(negedge clk);
      #5;
      if (!rst) begin
        exp = refControls(refDecode(modelIfId), modelEx, modelMem, branchTaken);
        checkValue("pcStall", exp.pcStall, pcStall);
        checkValue("ifIdStall", exp.ifIdStall, ifIdStall);
        checkValue("idFlush", exp.idFlush, idFlush);
        checkValue("ifFlush", exp.ifFlush, ifFlush);
        checkValue("exCtrl", modelEx, exCtrl);
        checkValue("loadUseCount", modelCount[0], loadUseCount);
        checkValue("branchStallCount", modelCount[1], branchStallCount);
        checkValue("haltStallCount", modelCount[2], haltStallCount);
        checkValue("flushCount", modelCount[3], flushCount);
      end
    end
  end

  //////////////////////////////
  // Fetch
  //////////////////////////////

  // Present one word and hold it while pcStall is up, returns the held cycles
  task automatic fetchWord(input logic [instrW-1:0] word, input logic taken,
                           output int holdCycles);
    int guard;
    holdCycles = 0;
    guard      = 0;
    @(negedge clk);
    instrWord   = word;
    branchTaken = taken;
    #5;
    while (pcStall && !taken) begin
      if (guard == waitLimit) failRun("fetch stayed held by pcStall past the timeout");
      guard++;
      holdCycles++;
      @(negedge clk);
      #5;
    end
  endtask

  task automatic drain(input int n);
    int hold;
    for (int i = 0; i < n; i++) fetchWord(fillWord, 1'b0, hold);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin : mainSeq
    int           hold;
    int           issued;
    int           cycles;
    logic         consumed;
    logic [15:0]  word;
    lfsrState   = 32'hb259_1b71;
    fillWord    = mkInstr(PADDSB, 4'd0, 4'd0, 4'd0);
    rst         = 1'b1;
    instrWord   = nopInstr;
    branchTaken = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    #5;

    // Quiet pipeline after reset
    checkValue("reset pcStall", 0, pcStall);
    checkValue("reset ifIdStall", 0, ifIdStall);
    checkValue("reset idFlush", 0, idFlush);
    checkValue("reset ifFlush", 0, ifFlush);
    checkValue("reset counters", 0, loadUseCount | branchStallCount | haltStallCount | flushCount);

    // Load-to-use
    fetchWord(mkInstr(LW, 4'd2, 4'd1, 4'd0), 1'b0, hold);
    fetchWord(mkInstr(ADD, 4'd5, 4'd2, 4'd3), 1'b0, hold);
    fetchWord(fillWord, 1'b0, hold);
    checkValue("load use stall cycles", 1, hold);
    checkValue("load use bubble", 0, exCtrl);
    fetchWord(mkInstr(LW, 4'd2, 4'd1, 4'd0), 1'b0, hold);
    fetchWord(mkInstr(SW, 4'd2, 4'd1, 4'd0), 1'b0, hold);   // Data reg matches
    fetchWord(fillWord, 1'b0, hold);
    checkValue("load then store stall cycles", 0, hold);
    fetchWord(mkInstr(LW, 4'd0, 4'd1, 4'd0), 1'b0, hold);
    fetchWord(mkInstr(ADD, 4'd5, 4'd0, 4'd0), 1'b0, hold);
    fetchWord(fillWord, 1'b0, hold);
    checkValue("load r0 stall cycles", 0, hold);

    // Branches, EX and MEM cleared of flag setters first
    drain(3);
    fetchWord(mkInstr(ADD, 4'd4, 4'd1, 4'd1), 1'b0, hold);
    fetchWord(mkInstr(B, 4'd0, 4'd0, 4'd0), 1'b0, hold);
    fetchWord(fillWord, 1'b0, hold);
    checkValue("B after ADD stall cycles", 1, hold);
    drain(3);
    fetchWord(mkInstr(RED, 4'd3, 4'd1, 4'd1), 1'b0, hold);
    fetchWord(mkInstr(BR, 4'd0, 4'd3, 4'd0), 1'b0, hold);
    fetchWord(fillWord, 1'b0, hold);
    checkValue("BR after r3 write stall cycles", 2, hold);   // EX then MEM
    drain(3);
    fetchWord(mkInstr(XOR, 4'd6, 4'd1, 4'd1), 1'b0, hold);
    fetchWord(mkInstr(BR, 4'd0, 4'd3, 4'd0), 1'b0, hold);
    fetchWord(fillWord, 1'b0, hold);
    checkValue("BR after XOR stall cycles", 1, hold);

    // Halt and fetch flush
    drain(3);
    fetchWord(mkInstr(HLT, 4'd0, 4'd0, 4'd0), 1'b0, hold);
    @(negedge clk);
    instrWord   = fillWord;
    branchTaken = 1'b0;
    #5;
    checkValue("halt pcStall", 1, pcStall);
    checkValue("halt ifIdStall", 0, ifIdStall);
    fetchWord(mkInstr(ADD, 4'd1, 4'd2, 4'd3), 1'b1, hold);
    checkValue("taken ifFlush", 1, ifFlush);
    @(negedge clk);
    instrWord   = fillWord;
    branchTaken = 1'b0;
    #5;
    checkValue("flushed decode word", nopInstr, DUT.ifIdInstr);
    checkValue("flushed decode pcStall", 0, pcStall);

    // Random run, fetch holds its word while pcStall is up
    issued   = 0;
    cycles   = 0;
    consumed = 1'b1;
    word     = fillWord;
    while (issued < randCount) begin
      if (cycles == randCycleLimit) failRun("random run did not issue all instructions in time");
      cycles++;
      @(negedge clk);
      if (consumed) word = randWord();
      branchTaken = (3'(takeBits(3)) == 3'd0);   // One in eight
      instrWord   = word;
      #5;
      consumed = !pcStall || branchTaken;        // Taken branch kills the word
      if (consumed) issued++;
    end

    checkValue("final loadUseCount", modelCount[0], loadUseCount);
    checkValue("final branchStallCount", modelCount[1], branchStallCount);
    checkValue("final haltStallCount", modelCount[2], haltStallCount);
    checkValue("final flushCount", modelCount[3], flushCount);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== hazardPipeCtrl.f ====
source/hazardPkg.sv
source/instrDecoder.sv
source/controlPipeline.sv
source/hazardDetectionUnit.sv
source/perfCounters.sv
source/hazardPipeCtrl.sv
dv/hazardPipeCtrlTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module hazardPipeCtrlTb \
  -f hazardPipeCtrl.f \
  --Mdir obj_dir -o simv

./obj_dir/simv
